// ==== rtl/conv_pkg.sv ====
package conv_pkg;

	// signed Q8.8 words for pixels, weights and results
	localparam int DATA_W = 16;
	localparam int FRAC_W = 8;
	// 25 products of 32 bits need no more than 37 bits
	localparam int ACC_W = 40;

	// output tile and lane array
	localparam int PARA_X = 3;
	localparam int PARA_Y = 3;
	localparam int LANES = PARA_X * PARA_Y;

	// kernel and patch limits
	localparam int KSIZE_MAX = 5;
	localparam int KSIZE_W = 3;
	localparam int PATCH_MAX = PARA_Y + KSIZE_MAX - 1;
	localparam int WGT_DEPTH = KSIZE_MAX * KSIZE_MAX;

	// counter widths: kernel steps, patch words, patch row/column index
	localparam int STEP_W = 5;
	localparam int PIX_W = 6;
	localparam int IDX_W = 3;

	// kernel edge, any value other than 5 runs as 3
	function automatic logic [IDX_W-1:0] k_edge(input logic [KSIZE_W-1:0] ksize);
		return (ksize == KSIZE_W'(5)) ? IDX_W'(5) : IDX_W'(3);
	endfunction

	// number of kernel positions, one compute step each
	function automatic logic [STEP_W-1:0] k_steps(input logic [KSIZE_W-1:0] ksize);
		return (ksize == KSIZE_W'(5)) ? STEP_W'(25) : STEP_W'(9);
	endfunction

endpackage

// ==== rtl/mac_unit.sv ====
`timescale 1ns/10ps

module mac_unit
	import conv_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              clear,
	input  logic              enable,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	output logic [DATA_W-1:0] result
);

	logic signed [2*DATA_W-1:0] product;
	logic signed [ACC_W-1:0]    acc;
	logic signed [ACC_W-1:0]    scaled;
	logic                       in_range;

	// full Q16.16 product, both operands signed
	assign product = $signed(a) * $signed(b);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			acc <= '0;
		else if (clear)
			acc <= '0;
		else if (enable)
			acc <= acc + {{(ACC_W-2*DATA_W){product[2*DATA_W-1]}}, product};
	end

	// back to Q8.8
	assign scaled = acc >>> FRAC_W;

	// the word fits when every bit above its sign bit matches the sign
	assign in_range = (&scaled[ACC_W-1:DATA_W-1]) || !(|scaled[ACC_W-1:DATA_W-1]);

	always_comb
	begin
		if (in_range)
			result = scaled[DATA_W-1:0];
		else if (acc[ACC_W-1])
			result = {1'b1, {(DATA_W-1){1'b0}}};
		else
			result = {1'b0, {(DATA_W-1){1'b1}}};
	end

endmodule

// ==== rtl/weight_buffer.sv ====
`timescale 1ns/10ps

module weight_buffer
	import conv_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic [KSIZE_W-1:0] ksize,
	input  logic               wgt_valid,
	input  logic [DATA_W-1:0]  wgt_data,
	input  logic               step_adv,
	input  logic               buf_release,
	output logic               wgt_ready,
	output logic               wgt_full,
	output logic [DATA_W-1:0]  cur_weight
);

	logic [STEP_W-1:0] k_sq;
	logic [STEP_W-1:0] wr_cnt;
	logic [STEP_W-1:0] rd_ptr;
	logic              load;

	// kernel weights, row-major
	logic [DATA_W-1:0] store [WGT_DEPTH];

	assign k_sq = k_steps(ksize);
	assign wgt_full = (wr_cnt == k_sq);
	assign wgt_ready = !wgt_full;
	assign load = wgt_valid && wgt_ready;

	// broadcast to all lanes during compute
	assign cur_weight = store[rd_ptr];

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			wr_cnt <= '0;
			rd_ptr <= '0;
		end
		else if (buf_release)
		begin
			wr_cnt <= '0;
			rd_ptr <= '0;
		end
		else if (load)
			wr_cnt <= wr_cnt + 1'b1;
		else if (step_adv)
			rd_ptr <= rd_ptr + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (load)
			store[wr_cnt] <= wgt_data;
	end

endmodule

// ==== rtl/patch_shifter.sv ====
`timescale 1ns/10ps

module patch_shifter
	import conv_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic [KSIZE_W-1:0]      ksize,
	input  logic                    pix_valid,
	input  logic [DATA_W-1:0]       pix_data,
	input  logic                    step_adv,
	input  logic                    buf_release,
	output logic                    pix_ready,
	output logic                    patch_full,
	output logic [LANES*DATA_W-1:0] taps
);

	logic [IDX_W-1:0] k;
	logic [IDX_W-1:0] row_edge;
	logic [IDX_W-1:0] col_edge;
	logic [PIX_W-1:0] patch_words;
	logic [PIX_W-1:0] pix_cnt;
	logic [IDX_W-1:0] ld_row;
	logic [IDX_W-1:0] ld_col;
	logic [IDX_W-1:0] col_step;
	logic             load;
	logic             row_wrap;

	// copy rows keep the patch unrotated, working rows feed the lanes
	logic [PATCH_MAX*DATA_W-1:0] copy_row [PATCH_MAX];
	logic [PATCH_MAX*DATA_W-1:0] work_row [PARA_X];

	assign k = k_edge(ksize);
	assign row_edge = IDX_W'(PARA_X - 1) + k;
	assign col_edge = IDX_W'(PARA_Y - 1) + k;
	assign patch_words = PIX_W'(row_edge) * PIX_W'(col_edge);

	assign patch_full = (pix_cnt == patch_words);
	assign pix_ready = !patch_full;
	assign load = pix_valid && pix_ready;

	// last column offset of the current kernel row
	assign row_wrap = (col_step == k - 1'b1);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			pix_cnt <= '0;
			ld_row <= '0;
			ld_col <= '0;
			col_step <= '0;
		end
		else if (buf_release)
		begin
			pix_cnt <= '0;
			ld_row <= '0;
			ld_col <= '0;
			col_step <= '0;
		end
		else if (load)
		begin
			pix_cnt <= pix_cnt + 1'b1;
			if (ld_col == col_edge - 1'b1)
			begin
				ld_col <= '0;
				ld_row <= ld_row + 1'b1;
			end
			else
				ld_col <= ld_col + 1'b1;
		end
		else if (step_adv)
			col_step <= row_wrap ? '0 : col_step + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			for (int r = 0; r < PATCH_MAX; r++)
			begin
				if (ld_row == IDX_W'(r))
					copy_row[r][ld_col*DATA_W +: DATA_W] <= pix_data;
			end
			// the first PARA_X patch rows are also the starting window
			for (int x = 0; x < PARA_X; x++)
			begin
				if (ld_row == IDX_W'(x))
					work_row[x][ld_col*DATA_W +: DATA_W] <= pix_data;
			end
		end
		else if (step_adv)
		begin
			if (row_wrap)
			begin
				// window moves down one patch row
				for (int r = 0; r < PATCH_MAX - 1; r++)
					copy_row[r] <= copy_row[r + 1];
				for (int x = 0; x < PARA_X; x++)
					work_row[x] <= copy_row[x + 1];
			end
			else
			begin
				// word y takes word y+1, so each lane sees the next column
				for (int x = 0; x < PARA_X; x++)
					work_row[x] <= {work_row[x][DATA_W-1:0],
						work_row[x][PATCH_MAX*DATA_W-1:DATA_W]};
			end
		end
	end

	// lane x,y reads working row x, word y
	always_comb
	begin
		for (int x = 0; x < PARA_X; x++)
		begin
			for (int y = 0; y < PARA_Y; y++)
				taps[(x*PARA_Y+y)*DATA_W +: DATA_W] = work_row[x][y*DATA_W +: DATA_W];
		end
	end

endmodule

// ==== rtl/conv_tile_engine.sv ====
`timescale 1ns/10ps

module conv_tile_engine
	import conv_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic [KSIZE_W-1:0]      ksize,
	input  logic                    wgt_full,
	input  logic                    patch_full,
	input  logic [DATA_W-1:0]       cur_weight,
	input  logic [LANES*DATA_W-1:0] taps,
	input  logic                    res_ready,
	output logic                    step_adv,
	output logic                    buf_release,
	output logic                    res_valid,
	output logic [LANES*DATA_W-1:0] res_data
);

	typedef enum logic [1:0]
	{
		S_IDLE,
		S_COMPUTE,
		S_HOLD
	} state_t;

	state_t            state;
	logic [STEP_W-1:0] k_sq;
	logic [STEP_W-1:0] step_cnt;
	logic              last_step;
	logic              lane_clear;
	logic              lane_en;
	logic [DATA_W-1:0] lane_res [LANES];

	assign k_sq = k_steps(ksize);
	assign last_step = (step_cnt == k_sq - 1'b1);

	// clear pulses as idle is left; buffers are still full while release is high
	assign lane_clear = (state == S_IDLE) && wgt_full && patch_full && !buf_release;
	assign lane_en = (state == S_COMPUTE);

	// no shift after the last kernel position
	assign step_adv = lane_en && !last_step;

	for (genvar i = 0; i < LANES; i++)
	begin : g_lane
		mac_unit u_mac
		(
			.clk    (clk),
			.rst    (rst),
			.clear  (lane_clear),
			.enable (lane_en),
			.a      (taps[i*DATA_W +: DATA_W]),
			.b      (cur_weight),
			.result (lane_res[i])
		);
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= S_IDLE;
			step_cnt <= '0;
			res_valid <= 1'b0;
			buf_release <= 1'b0;
		end
		else
		begin
			buf_release <= 1'b0;
			case (state)
				S_IDLE:
				begin
					if (lane_clear)
					begin
						state <= S_COMPUTE;
						step_cnt <= '0;
					end
				end
				S_COMPUTE:
				begin
					if (last_step)
						state <= S_HOLD;
					else
						step_cnt <= step_cnt + 1'b1;
				end
				S_HOLD:
				begin
					// first cycle lets the last product settle, then the tile is offered
					if (!res_valid)
						res_valid <= 1'b1;
					else if (res_ready)
					begin
						res_valid <= 1'b0;
						buf_release <= 1'b1;
						state <= S_IDLE;
					end
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// gather all lanes into one word, lane 0 lowest
	always_ff @(posedge clk)
	begin
		if ((state == S_HOLD) && !res_valid)
		begin
			for (int i = 0; i < LANES; i++)
				res_data[i*DATA_W +: DATA_W] <= lane_res[i];
		end
	end

endmodule

// ==== rtl/conv_tile_top.sv ====
`timescale 1ns/10ps

module conv_tile_top
	import conv_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic [KSIZE_W-1:0]      ksize,
	input  logic                    pix_valid,
	input  logic [DATA_W-1:0]       pix_data,
	output logic                    pix_ready,
	input  logic                    wgt_valid,
	input  logic [DATA_W-1:0]       wgt_data,
	output logic                    wgt_ready,
	output logic                    res_valid,
	output logic [LANES*DATA_W-1:0] res_data,
	input  logic                    res_ready
);

	logic                    wgt_full;
	logic                    patch_full;
	logic [DATA_W-1:0]       cur_weight;
	logic [LANES*DATA_W-1:0] taps;
	logic                    step_adv;
	logic                    buf_release;

	weight_buffer u_weight_buffer
	(
		.clk         (clk),
		.rst         (rst),
		.ksize       (ksize),
		.wgt_valid   (wgt_valid),
		.wgt_data    (wgt_data),
		.step_adv    (step_adv),
		.buf_release (buf_release),
		.wgt_ready   (wgt_ready),
		.wgt_full    (wgt_full),
		.cur_weight  (cur_weight)
	);

	// loader side fills it, the engine steps it
	patch_shifter u_patch_shifter
	(
		.clk         (clk),
		.rst         (rst),
		.ksize       (ksize),
		.pix_valid   (pix_valid),
		.pix_data    (pix_data),
		.step_adv    (step_adv),
		.buf_release (buf_release),
		.pix_ready   (pix_ready),
		.patch_full  (patch_full),
		.taps        (taps)
	);

	conv_tile_engine u_engine
	(
		.clk         (clk),
		.rst         (rst),
		.ksize       (ksize),
		.wgt_full    (wgt_full),
		.patch_full  (patch_full),
		.cur_weight  (cur_weight),
		.taps        (taps),
		.res_ready   (res_ready),
		.step_adv    (step_adv),
		.buf_release (buf_release),
		.res_valid   (res_valid),
		.res_data    (res_data)
	);

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen
(
	output logic clk,
	output logic rst
);

	localparam int HALF_PERIOD = 5;
	localparam int RESET_CYCLES = 4;

	initial
	begin
		clk = 1'b0;
		forever
			#(HALF_PERIOD) clk = ~clk;
	end

	// active low reset, released just after the fourth rising edge
	initial
	begin
		rst = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		#1;
		rst = 1'b1;
	end

endmodule

// ==== tests/tb_conv_tile.sv ====
`timescale 1ns/10ps

module tb_conv_tile
	import conv_pkg::*;
();

	localparam int N_K3 = 4;
	localparam int N_K5 = 4;
	localparam int N_SAT = 2;
	localparam int N_BP = 3;
	localparam int N_TILES = N_K3 + N_K5 + N_SAT + N_BP;
	localparam int CLK_PERIOD = 10;
	// worst patch, worst kernel and handshake slack per tile
	localparam int TILE_CYCLES = 49 + 25 + 40;
	localparam longint TIMEOUT_NS = N_TILES * TILE_CYCLES * CLK_PERIOD * 2 + 500;
	localparam longint MAX_WORD = (longint'(1) << (DATA_W - 1)) - 1;
	localparam longint MIN_WORD = -(longint'(1) << (DATA_W - 1));

	logic                    clk;
	logic                    rst;
	logic [KSIZE_W-1:0]      ksize;
	logic                    pix_valid;
	logic [DATA_W-1:0]       pix_data;
	logic                    pix_ready;
	logic                    wgt_valid;
	logic [DATA_W-1:0]       wgt_data;
	logic                    wgt_ready;
	logic                    res_valid;
	logic [LANES*DATA_W-1:0] res_data;
	logic                    res_ready;

	integer seed;
	logic signed [DATA_W-1:0] patch [PATCH_MAX][PATCH_MAX];
	logic signed [DATA_W-1:0] weights [KSIZE_MAX][KSIZE_MAX];
	logic [DATA_W-1:0]        expected [LANES];

	// previous negedge view of the result port
	logic                    prev_valid;
	logic                    prev_ready;
	logic [LANES*DATA_W-1:0] prev_data;

	tb_clock_gen u_clock_gen
	(
		.clk (clk),
		.rst (rst)
	);

	conv_tile_top DUT
	(
		.clk       (clk),
		.rst       (rst),
		.ksize     (ksize),
		.pix_valid (pix_valid),
		.pix_data  (pix_data),
		.pix_ready (pix_ready),
		.wgt_valid (wgt_valid),
		.wgt_data  (wgt_data),
		.wgt_ready (wgt_ready),
		.res_valid (res_valid),
		.res_data  (res_data),
		.res_ready (res_ready)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	// uniform in -4.0 .. +4.0 as Q8.8
	function automatic logic signed [DATA_W-1:0] small_value();
		return DATA_W'($random(seed) % 1025);
	endfunction

	task automatic fill_random();
		for (int r = 0; r < PATCH_MAX; r++)
		begin
			for (int c = 0; c < PATCH_MAX; c++)
				patch[r][c] = small_value();
		end
		for (int r = 0; r < KSIZE_MAX; r++)
		begin
			for (int c = 0; c < KSIZE_MAX; c++)
				weights[r][c] = small_value();
		end
	endtask

	// large positive pixels; weights of one sign push every lane past the limit
	task automatic fill_saturating(input bit negative);
		for (int r = 0; r < PATCH_MAX; r++)
		begin
			for (int c = 0; c < PATCH_MAX; c++)
				patch[r][c] = 16'sh7800 + DATA_W'({$random(seed)} % 256);
		end
		for (int r = 0; r < KSIZE_MAX; r++)
		begin
			for (int c = 0; c < KSIZE_MAX; c++)
				weights[r][c] = (negative ? 16'sh8100 : 16'sh7800) + DATA_W'({$random(seed)} % 256);
		end
	endtask

	// sum of products over the window, back to Q8.8, clamped to one word
	task automatic compute_expected(input int k);
		longint sum;
		longint scaled;
		for (int x = 0; x < PARA_X; x++)
		begin
			for (int y = 0; y < PARA_Y; y++)
			begin
				sum = 0;
				for (int kx = 0; kx < k; kx++)
				begin
					for (int ky = 0; ky < k; ky++)
						sum += longint'(patch[x+kx][y+ky]) * longint'(weights[kx][ky]);
				end
				scaled = sum >>> FRAC_W;
				if (scaled > MAX_WORD)
					expected[x*PARA_Y+y] = 16'h7fff;
				else if (scaled < MIN_WORD)
					expected[x*PARA_Y+y] = 16'h8000;
				else
					expected[x*PARA_Y+y] = DATA_W'(scaled);
			end
		end
	endtask

	// caller sits 1 ns after a rising edge; ready is stable there
	task automatic send_patch(input int k, input int max_gap);
		int gap;
		for (int r = 0; r < PARA_X + k - 1; r++)
		begin
			for (int c = 0; c < PARA_Y + k - 1; c++)
			begin
				gap = (max_gap > 0) ? {$random(seed)} % (max_gap + 1) : 0;
				pix_valid = 1'b0;
				repeat (gap)
				begin
					@(posedge clk);
					#1;
				end
				pix_valid = 1'b1;
				pix_data = patch[r][c];
				while (!pix_ready)
				begin
					@(posedge clk);
					#1;
				end
				@(posedge clk);
				#1;
			end
		end
		pix_valid = 1'b0;
	endtask

	task automatic send_weights(input int k, input int max_gap);
		int gap;
		for (int r = 0; r < k; r++)
		begin
			for (int c = 0; c < k; c++)
			begin
				gap = (max_gap > 0) ? {$random(seed)} % (max_gap + 1) : 0;
				wgt_valid = 1'b0;
				repeat (gap)
				begin
					@(posedge clk);
					#1;
				end
				wgt_valid = 1'b1;
				wgt_data = weights[r][c];
				while (!wgt_ready)
				begin
					@(posedge clk);
					#1;
				end
				@(posedge clk);
				#1;
			end
		end
		wgt_valid = 1'b0;
	endtask

	// order 0 sends weights first, 1 the patch first, 2 both at once
	task automatic run_tile(input int k, input int order, input int max_gap, input int hold);
		ksize = KSIZE_W'(k);
		compute_expected(k);
		if (order == 0)
		begin
			send_weights(k, max_gap);
			send_patch(k, max_gap);
		end
		else if (order == 1)
		begin
			send_patch(k, max_gap);
			send_weights(k, max_gap);
		end
		else
		begin
			fork
				send_patch(k, max_gap);
				send_weights(k, max_gap);
			join
		end
		while (!res_valid)
		begin
			@(posedge clk);
			#1;
		end
		for (int i = 0; i < LANES; i++)
		begin
			assert (res_data[i*DATA_W +: DATA_W] === expected[i])
			else
				report_failure($sformatf("Error: res_data lane %0d expected %h got %h",
					i, expected[i], res_data[i*DATA_W +: DATA_W]));
		end
		repeat (hold)
		begin
			@(posedge clk);
			#1;
		end
		res_ready = 1'b1;
		@(posedge clk);
		#1;
		res_ready = 1'b0;
		// release takes one cycle, the buffers reopen on the next
		@(posedge clk);
		#1;
		assert (pix_ready && wgt_ready)
		else
			report_failure("load readys did not return high after the result was accepted");
	endtask

	// result port watch, sampled on the falling edge
	always @(negedge clk)
	begin
		if (rst)
		begin
			if (prev_valid && !prev_ready)
			begin
				assert (res_valid)
				else
					report_failure("res_valid dropped before the result was accepted");
				assert (res_data === prev_data)
				else
					report_failure($sformatf("Error: res_data changed while held, was %h now %h",
						prev_data, res_data));
			end
			if (res_valid)
			begin
				assert (!pix_ready && !wgt_ready)
				else
					report_failure("a load ready was high while a result was pending");
			end
		end
		prev_valid = rst && res_valid;
		prev_ready = res_ready;
		prev_data = res_data;
	end

	initial
	begin
		#(TIMEOUT_NS);
		report_failure("watchdog expired before all tiles completed");
	end

	initial
	begin
		seed = 32'h4e4111a2;
		ksize = KSIZE_W'(3);
		pix_valid = 1'b0;
		pix_data = '0;
		wgt_valid = 1'b0;
		wgt_data = '0;
		res_ready = 1'b0;
		@(posedge rst);
		@(posedge clk);
		#1;
		assert (!res_valid && pix_ready && wgt_ready)
		else
			report_failure("port state after reset is wrong");

		for (int t = 0; t < N_K3; t++)
		begin
			fill_random();
			run_tile(3, t % 2, 0, 0);
		end

		for (int t = 0; t < N_K5; t++)
		begin
			fill_random();
			run_tile(5, 2, 3, 0);
		end

		for (int t = 0; t < N_SAT; t++)
		begin
			fill_saturating(t % 2);
			compute_expected(3 + 2 * (t % 2));
			for (int i = 0; i < LANES; i++)
			begin
				assert (expected[i] == ((t % 2) ? 16'h8000 : 16'h7fff))
				else
					report_failure("saturation stimulus does not reach the word limit");
			end
			run_tile(3 + 2 * (t % 2), 2, 0, 0);
		end

		// random hold on res_ready, then the next tile must still be right
		for (int t = 0; t < N_BP; t++)
		begin
			fill_random();
			run_tile(3 + 2 * (t % 2), 2, 1, 3 + {$random(seed)} % 16);
		end

		$display("sim passed");
		$finish;
	end

endmodule

// ==== verilog.f ====
rtl/conv_pkg.sv
rtl/mac_unit.sv
rtl/weight_buffer.sv
rtl/patch_shifter.sv
rtl/conv_tile_engine.sv
rtl/conv_tile_top.sv
tests/tb_clock_gen.sv
tests/tb_conv_tile.sv
